/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    localparam PROGRAM_FILE   = "program.hex";

    localparam int UART_CLKS_PER_BIT = 8; // Short bit time keeps simulation quick
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

    // RV32I major opcodes, plus custom-0 for OUT
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;

    typedef enum logic [2:0] {
        PH_FETCH, PH_DECODE, PH_EXEC, PH_MEM, PH_WB, PH_OUT
    } phase_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        word_t     imm;
        alu_op_t   alu_op;
        logic      alu_src_imm;
        logic      alu_pc;
        logic      branch_eq;
        logic      branch_ne;
        logic      jump;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
        logic      out_op;
    } ctrl_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
        logic      take_branch;
        word_t     branch_target;
    } ex_t;

    typedef struct packed {
        word_t     wdata;
        logic      reg_write;
        reg_addr_t rd;
        logic      take_branch;
        word_t     branch_target;
    } wb_t;

endpackage

`default_nettype wire

/* source/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  phase_t phase,
    input  word_t  pc,
    output word_t  instr
);

    word_t rom [IMEM_WORDS];

    initial begin
        $readmemh(PROGRAM_FILE, rom);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0; // Opcode zero decodes as a no-op
        end else if (phase == PH_FETCH) begin
            instr <= rom[pc[IMEM_AW+1:2]];
        end
    end

endmodule

`default_nettype wire

/* source/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  phase_t    phase,
    input  word_t     instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output ctrl_t     ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    ctrl_t      dec;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec = '0;
        dec.alu_op = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                dec.rd = instr[11:7];
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.reg_write = 1'b0; // Shifts and SLTU are not supported
                endcase
            end
            OPC_OP_IMM: begin
                dec.imm = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.rd = instr[11:7];
                dec.reg_write = (funct3 == 3'b000); // Only ADDI
            end
            OPC_LUI: begin
                dec.imm = imm_u;
                dec.alu_src_imm = 1'b1;
                dec.alu_op = ALU_PASS_B;
                dec.rd = instr[11:7];
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.imm = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.mem_read = (funct3 == 3'b010);
                dec.rd = instr[11:7];
                dec.reg_write = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                dec.imm = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.mem_write = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                dec.branch_eq = (funct3 == 3'b000);
                dec.branch_ne = (funct3 == 3'b001);
            end
            OPC_JAL: begin
                // The ALU forms the link address from the PC
                dec.imm = imm_j;
                dec.alu_pc = 1'b1;
                dec.jump = 1'b1;
                dec.rd = instr[11:7];
                dec.reg_write = 1'b1;
            end
            OPC_CUSTOM0: dec.out_op = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs1 <= '0;
            rs2 <= '0;
            ctrl <= '0;
        end else if (phase == PH_DECODE) begin
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            ctrl <= dec;
        end
    end

    // A word access is either a load or a store, never both
    assert property (@(posedge clk) disable iff (rst) !(ctrl.mem_read && ctrl.mem_write));

endmodule

`default_nettype wire

/* source/exec.sv */
`timescale 1ns/1ps
`default_nettype none

module exec import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  phase_t phase,
    input  word_t  pc,
    input  ctrl_t  ctrl,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    output ex_t    ex
);

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t target;
    logic  equal;
    logic  take;

    assign op_a = ctrl.alu_pc ? pc : rs1_data;
    // JAL adds 4 to the PC to form the link address
    assign op_b = ctrl.jump ? word_t'(4) : (ctrl.alu_src_imm ? ctrl.imm : rs2_data);

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign target = pc + ctrl.imm;
    assign equal = (rs1_data == rs2_data);
    assign take = ctrl.jump | (ctrl.branch_eq & equal) | (ctrl.branch_ne & ~equal);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex <= '0;
        end else if (phase == PH_EXEC) begin
            ex.result <= alu_out;
            ex.store_data <= rs2_data;
            ex.mem_read <= ctrl.mem_read;
            ex.mem_write <= ctrl.mem_write;
            ex.reg_write <= ctrl.reg_write;
            ex.rd <= ctrl.rd;
            ex.take_branch <= take;
            ex.branch_target <= target;
        end
    end

endmodule

`default_nettype wire

/* source/mem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  phase_t phase,
    input  ex_t    ex,
    output wb_t    wb
);

    word_t               ram [DMEM_WORDS];
    logic [DMEM_AW-1:0]  addr;
    word_t               rdata;

    assign addr = ex.result[DMEM_AW+1:2]; // Word addressed
    assign rdata = ram[addr];

    always_ff @(posedge clk) begin
        if (phase == PH_MEM && ex.mem_write) begin
            ram[addr] <= ex.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else if (phase == PH_MEM) begin
            wb.wdata <= ex.mem_read ? rdata : ex.result;
            wb.reg_write <= ex.reg_write;
            wb.rd <= ex.rd;
            wb.take_branch <= ex.take_branch;
            wb.branch_target <= ex.branch_target;
        end
    end

endmodule

`default_nettype wire

/* source/registerfile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerfile import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     wdata,
    input  logic      we,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     test
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata; // x0 is never written so it reads as zero
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // Debug view of a0
    assign test = regs[10];

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t data,
    input  logic  send,
    output logic  busy,
    output logic  tx
);

    logic [UART_CNT_W-1:0] clk_cnt;
    logic [3:0]            bit_idx;
    logic [8:0]            shreg;
    logic                  bit_end;

    assign bit_end = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            tx <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (send) begin
                busy <= 1'b1;
                tx <= 1'b0; // Start bit
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                // End of the stop bit
                busy <= 1'b0;
                tx <= 1'b1;
            end else begin
                tx <= shreg[0];
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Data bits LSB first, then the stop bit
    always_ff @(posedge clk) begin
        if (!busy && send) begin
            shreg <= {1'b1, data};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

`default_nettype wire

/* source/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output word_t test,
    output logic  uart_output
);

    phase_t    phase;
    word_t     pc;
    word_t     instr;
    reg_addr_t rs1, rs2;
    ctrl_t     ctrl;
    word_t     rs1_data, rs2_data;
    ex_t       ex;
    wb_t       wb;
    logic      reg_we;
    logic      send;
    logic      busy;

    fetch u_fetch (
        .clk(clk), .rst(rst), .phase(phase), .pc(pc), .instr(instr)
    );

    decode u_decode (
        .clk(clk), .rst(rst), .phase(phase), .instr(instr),
        .rs1(rs1), .rs2(rs2), .ctrl(ctrl)
    );

    registerfile u_registerfile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(wb.rd),
        .wdata(wb.wdata), .we(reg_we),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .test(test)
    );

    exec u_exec (
        .clk(clk), .rst(rst), .phase(phase), .pc(pc), .ctrl(ctrl),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .ex(ex)
    );

    mem u_mem (
        .clk(clk), .rst(rst), .phase(phase), .ex(ex), .wb(wb)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst(rst), .data(rs1_data[7:0]), .send(send),
        .busy(busy), .tx(uart_output)
    );

    assign reg_we = (phase == PH_WB) && wb.reg_write;
    assign send = (phase == PH_OUT) && !busy; // rs1 is already registered by decode here

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_FETCH;
            pc <= '0;
        end else begin
            case (phase)
                PH_FETCH:  phase <= PH_DECODE;
                PH_DECODE: phase <= (instr[6:0] == OPC_CUSTOM0) ? PH_OUT : PH_EXEC;
                PH_EXEC:   phase <= PH_MEM;
                PH_MEM:    phase <= PH_WB;
                PH_WB: begin
                    pc <= wb.take_branch ? wb.branch_target : pc + 32'd4;
                    phase <= PH_FETCH;
                end
                PH_OUT: begin
                    if (!busy) begin
                        phase <= PH_EXEC; // OUT finishes as a no-op
                    end
                end
                default:   phase <= PH_FETCH;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

    // The transmitter is idle when a byte is handed over and busy right after
    assert property (@(posedge clk) disable iff (rst) send |-> !busy ##1 busy);

endmodule

`default_nettype wire

/* test/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int RESET_CYCLES  = 5;
    localparam int BYTE_COUNT    = 6;
    localparam int BYTE_TIMEOUT  = 1000; // Clocks allowed between two received bytes
    localparam int QUIET_BITS    = 200;
    localparam int HALF_BIT      = UART_CLKS_PER_BIT / 2;

    logic  clk = 1'b0;
    logic  rst;
    word_t test;
    logic  uart_output;

    logic  reset_window;
    logic  result_window;
    logic  quiet_window;
    int    value_errors = 0;
    int    timeouts = 0;

    // Frame decoder state
    logic       rx_active = 1'b0;
    int         rx_cnt = 0;
    logic [7:0] rx_shift = '0;
    logic       rx_start = 1'b0;
    logic       rx_stop = 1'b1;
    byte_t      rx_byte = '0;
    int         rx_index = 0;
    logic       frame_done = 1'b0;
    byte_t      rx_queue[$];

    core UUT (
        .clk(clk),
        .rst(rst),
        .test(test),
        .uart_output(uart_output)
    );

    always #10 clk = ~clk;

    // The program prints 'A' to 'E' and then a line feed
    function automatic byte_t expected_byte(input int idx);
        if (idx < 5) begin
            return byte_t'(8'h41 + idx);
        end else begin
            return 8'h0A;
        end
    endfunction

    task automatic log_failure(input string msg);
        value_errors++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    // Samples on falling edges because the line only moves on rising ones
    always @(negedge clk) begin
        frame_done <= 1'b0;
        if (rst) begin
            rx_active <= 1'b0;
            rx_cnt <= 0;
        end else if (!rx_active) begin
            if (!uart_output) begin
                rx_active <= 1'b1; // Start bit seen
                rx_cnt <= 1;
            end
        end else begin
            rx_cnt <= rx_cnt + 1;
            if (rx_cnt == HALF_BIT) begin
                rx_start <= uart_output;
            end else if (rx_cnt == 9 * UART_CLKS_PER_BIT + HALF_BIT) begin
                rx_stop <= uart_output;
                rx_byte <= rx_shift;
                rx_index <= rx_queue.size();
                rx_queue.push_back(rx_shift);
                frame_done <= 1'b1;
                rx_active <= 1'b0;
            end else if (rx_cnt % UART_CLKS_PER_BIT == HALF_BIT) begin
                rx_shift <= {uart_output, rx_shift[7:1]}; // LSB first
            end
        end
    end

    assert property (@(posedge clk) reset_window |-> (uart_output && test == '0))
        else log_failure("UART line not idle or test not zero around reset");

    assert property (@(posedge clk) frame_done |-> !rx_start)
        else log_failure("start bit not low at mid-bit");

    assert property (@(posedge clk) frame_done |-> rx_stop)
        else log_failure("stop bit not high at mid-bit");

    assert property (@(posedge clk) frame_done |-> rx_index < BYTE_COUNT)
        else log_failure($sformatf("unexpected extra byte 0x%02h", rx_byte));

    assert property (@(posedge clk) frame_done |-> rx_byte == expected_byte(rx_index))
        else log_failure($sformatf("byte %0d is 0x%02h, expected 0x%02h",
                                   rx_index, rx_byte, expected_byte(rx_index)));

    assert property (@(posedge clk) result_window |-> test == 32'd126)
        else log_failure($sformatf("x10 is %0d, expected 126", test));

    assert property (@(posedge clk) quiet_window |-> uart_output)
        else log_failure("UART line left idle during the spin loop");

    task automatic wait_for_bytes(input int count);
        int cycles;
        cycles = 0;
        while (rx_queue.size() < count && cycles < BYTE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_queue.size() < count) begin
            timeouts++;
            $display("Timed out after %0d clocks waiting for UART byte %0d", cycles, count);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d failed checks, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        reset_window = 1'b0;
        result_window = 1'b0;
        quiet_window = 1'b0;

        @(negedge clk);
        reset_window = 1'b1; // First edge has already reset the line and registers
        repeat (RESET_CYCLES - 1) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);
        reset_window = 1'b0;

        for (int i = 1; i <= BYTE_COUNT && timeouts == 0; i++) begin
            wait_for_bytes(i);
        end

        if (timeouts == 0) begin
            result_window = 1'b1;
            quiet_window = 1'b1; // Only the JAL spin runs from here on
            repeat (QUIET_BITS * UART_CLKS_PER_BIT) @(negedge clk);
            assert (rx_queue.size() == BYTE_COUNT)
                else log_failure($sformatf("received %0d bytes", rx_queue.size()));
        end

        finish_run();
    end

endmodule

`default_nettype wire

/* test/program.hex */
// One 32-bit instruction word per line, starting at address 0
04100093 // addi x1, x0, 0x41
04600113 // addi x2, x0, 0x46
0000800B // out x1
00108093 // addi x1, x1, 1
FE209CE3 // bne x1, x2, -8
07B00193 // addi x3, x0, 123
00302823 // sw x3, 16(x0)
01002583 // lw x11, 16(x0)
00500213 // addi x4, x0, 5
00200293 // addi x5, x0, 2
40520333 // sub x6, x4, x5
0042A3B3 // slt x7, x5, x4
00737433 // and x8, x6, x7
008364B3 // or x9, x6, x8
12345037 // lui x0, 0x12345
00958533 // add x10, x11, x9
00054533 // xor x10, x10, x0
00A00693 // addi x13, x0, 10
0006800B // out x13
0000006F // jal x0, 0

/* core.f */
source/core_pkg.sv
source/fetch.sv
source/decode.sv
source/exec.sv
source/mem.sv
source/registerfile.sv
source/uart_tx.sv
source/core.sv
test/core_tb.sv

/* run.sh */
#!/bin/sh
# Builds the core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module core_tb -f core.f -Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# The ROM image is loaded by its bare name, so the model runs from test/
(cd test && ../obj_dir/core_sim) > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
